// ==== source/matmul_settings.svh ====
// Matmul sizes and widths
`ifndef MATMUL_SETTINGS_SVH
`define MATMUL_SETTINGS_SVH

// Rows of A, also rows of C
`define MM_ROWS 4

// Rows of B, one per output column of C
`define MM_COLS 4

// Inner dimension K
`define MM_INNER 16

// Elements packed in one RAM word
`define MM_CHUNK 4

// Words per row, K / CHUNK
`define MM_KCH (`MM_INNER / `MM_CHUNK)

`define MM_ELEM_W 8   // Signed operand width
`define MM_FRAC 4     // Right shift on the finished sum
`define MM_OUT_W 16   // Result width
`define MM_SUM_W 24   // Accumulator width

// Read issue to output register, in cycles
// RAM, product, chunk sum, accumulator
`define MM_PIPE_LAT 4

`endif

// ==== source/matmul_pkg.sv ====
// Matmul shared types
`include "matmul_settings.svh"

package matmul_pkg;

    // Single signed operand
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // One RAM word, lane 0 in the low bits
    typedef logic [`MM_CHUNK*`MM_ELEM_W-1:0] word_t;

    // A holds ROWS x KCH words
    typedef logic [$clog2(`MM_ROWS*`MM_KCH)-1:0] a_addr_t;

    // B holds COLS x KCH words, one row per output column
    typedef logic [$clog2(`MM_COLS*`MM_KCH)-1:0] b_addr_t;

    typedef logic signed [`MM_SUM_W-1:0] sum_t;   // Running dot product
    typedef logic [`MM_OUT_W-1:0] result_t;       // Shifted, truncated element

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,       // Loading allowed, waiting for start
        RUN,        // One read per cycle
        DRAIN,      // Waiting on the engine pipeline
        FINISHED    // done high, loading allowed again
    } seq_state_t;

endpackage

// ==== source/dual_port_bram.sv ====
// Behavioural block RAM
// One write port, one registered read port
`timescale 1ns/1ps

module dual_port_bram #(
    parameter int DATA_W = 32,
    parameter int DEPTH = 16,
    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic              clk,

    // Write side, used during loading
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,

    // Read side, used during compute
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    // Storage array, contents undefined until loaded
    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr]; // Holds last word when idle
        end
    end

endmodule

// ==== source/tile_sequencer.sv ====
// Tile sequencer
// Walks C in row-major order, one chunk read per cycle
`timescale 1ns/1ps
`include "matmul_settings.svh"

module tile_sequencer import matmul_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,

    output logic    load_open,    // External writes allowed
    output logic    rd_en,
    output a_addr_t a_rd_addr,
    output b_addr_t b_rd_addr,
    output logic    chunk_valid,  // Tags travel with the read
    output logic    chunk_first,
    output logic    chunk_last,
    output logic    done
);

    // Counter widths, at least one bit each
    localparam int CH_W  = (`MM_KCH > 1) ? $clog2(`MM_KCH) : 1;
    localparam int COL_W = (`MM_COLS > 1) ? $clog2(`MM_COLS) : 1;
    localparam int ROW_W = (`MM_ROWS > 1) ? $clog2(`MM_ROWS) : 1;
    localparam int DR_W  = $clog2(`MM_PIPE_LAT + 1);

    seq_state_t state;

    logic [CH_W-1:0]  chunk_cnt;  // Chunk along K
    logic [COL_W-1:0] col_cnt;    // Column of C, row of B
    logic [ROW_W-1:0] row_cnt;    // Row of C and A
    logic [DR_W-1:0]  drain_cnt;  // Cycles spent in DRAIN

    logic chunk_wrap;
    logic col_wrap;
    logic last_read;

    assign chunk_wrap = (chunk_cnt == CH_W'(`MM_KCH - 1));
    assign col_wrap   = (col_cnt == COL_W'(`MM_COLS - 1));
    // Final chunk of the final element
    assign last_read  = chunk_wrap && col_wrap && (row_cnt == ROW_W'(`MM_ROWS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            chunk_cnt <= '0;
            col_cnt   <= '0;
            row_cnt   <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE, FINISHED: begin
                    if (start) begin
                        state     <= RUN; // First read next cycle
                        chunk_cnt <= '0;
                        col_cnt   <= '0;
                        row_cnt   <= '0;
                    end
                end

                RUN: begin
                    // Chunk -> column -> row
                    if (chunk_wrap) begin
                        chunk_cnt <= '0;
                        if (col_wrap) begin
                            col_cnt <= '0;
                            row_cnt <= row_cnt + 1'b1;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end else begin
                        chunk_cnt <= chunk_cnt + 1'b1;
                    end

                    if (last_read) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end

                DRAIN: begin
                    // Last result leaves the engine on the final drain cycle
                    if (drain_cnt == DR_W'(`MM_PIPE_LAT - 1)) begin
                        state <= FINISHED;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // Reads issue straight from state, no gaps
    assign rd_en       = (state == RUN);
    assign chunk_valid = rd_en;
    assign chunk_first = rd_en && (chunk_cnt == '0);
    assign chunk_last  = rd_en && chunk_wrap;

    // Word address is row * KCH + chunk
    assign a_rd_addr = a_addr_t'(row_cnt * `MM_KCH + chunk_cnt);
    assign b_rd_addr = b_addr_t'(col_cnt * `MM_KCH + chunk_cnt);

    assign load_open = (state == IDLE) || (state == FINISHED);
    assign done      = (state == FINISHED); // Held until next start

endmodule

// ==== source/dot_product_engine.sv ====
// Dot-product engine
// Lane multiply, chunk sum, accumulate, fraction shift
`timescale 1ns/1ps
`include "matmul_settings.svh"

module dot_product_engine import matmul_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  word_t   a_word,       // From A RAM, one cycle after the read
    input  word_t   b_word,       // From B RAM
    input  logic    chunk_valid,  // Tags issued with the read
    input  logic    chunk_first,
    input  logic    chunk_last,
    output result_t out_data,
    output logic    out_valid
);

    localparam int PROD_W = 2 * `MM_ELEM_W;

    // Tags lined up with RAM data
    logic valid_q1, first_q1, last_q1;
    // Tags alongside the products
    logic valid_q2, first_q2, last_q2;
    // Tags alongside the chunk sum
    logic valid_q3, first_q3, last_q3;

    logic signed [PROD_W-1:0] prod_q [`MM_CHUNK];
    sum_t lane_sum;
    sum_t csum_q;
    sum_t acc_q;
    sum_t acc_next;

    // Tag pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
            valid_q3 <= 1'b0;
        end else begin
            valid_q1 <= chunk_valid;
            valid_q2 <= valid_q1;
            valid_q3 <= valid_q2;
        end
        first_q1 <= chunk_first;
        last_q1  <= chunk_last;
        first_q2 <= first_q1;
        last_q2  <= last_q1;
        first_q3 <= first_q2;
        last_q3  <= last_q2;
    end

    // Stage 2: signed lane products
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MM_CHUNK; i++) begin
            prod_q[i] <= elem_t'(a_word[i*`MM_ELEM_W +: `MM_ELEM_W]) *
                         elem_t'(b_word[i*`MM_ELEM_W +: `MM_ELEM_W]);
        end
    end

    // Adder tree, sign extended to accumulator width
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `MM_CHUNK; i++) begin
            lane_sum = lane_sum + sum_t'(prod_q[i]);
        end
    end

    // Stage 3: chunk sum
    always_ff @(posedge clk) begin
        csum_q <= lane_sum;
    end

    // First chunk restarts the element
    assign acc_next = first_q3 ? csum_q : acc_q + csum_q;

    // Stage 4: accumulator and output register
    always_ff @(posedge clk) begin
        if (valid_q3) begin
            acc_q <= acc_next;
            if (last_q3) begin
                out_data <= result_t'(acc_next >>> `MM_FRAC); // Keep low OUT_W bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid_q3 && last_q3; // One pulse per element
        end
    end

endmodule

// ==== source/matmul_top.sv ====
// Matmul top
// Two RAMs, sequencer and dot-product engine
`timescale 1ns/1ps
`include "matmul_settings.svh"

module matmul_top import matmul_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,

    // A matrix load port
    input  logic    a_wr_en,
    input  a_addr_t a_wr_addr,
    input  word_t   a_wr_data,

    // B matrix load port, one row per output column
    input  logic    b_wr_en,
    input  b_addr_t b_wr_addr,
    input  word_t   b_wr_data,

    output result_t out_data,
    output logic    out_valid,
    output logic    done
);

    logic    load_open;
    logic    rd_en;
    a_addr_t a_rd_addr;
    b_addr_t b_rd_addr;
    word_t   a_rd_word;
    word_t   b_rd_word;
    logic    chunk_valid;
    logic    chunk_first;
    logic    chunk_last;

    // Writes dropped while a job runs
    logic a_bram_wr_en;
    logic b_bram_wr_en;

    assign a_bram_wr_en = a_wr_en & load_open;
    assign b_bram_wr_en = b_wr_en & load_open;

    dual_port_bram #(
        .DATA_W ($bits(word_t)),
        .DEPTH  (`MM_ROWS * `MM_KCH)
    ) a_bram_i (
        .clk     (clk),
        .wr_en   (a_bram_wr_en),
        .wr_addr (a_wr_addr),
        .wr_data (a_wr_data),
        .rd_en   (rd_en),
        .rd_addr (a_rd_addr),
        .rd_data (a_rd_word)
    );

    dual_port_bram #(
        .DATA_W ($bits(word_t)),
        .DEPTH  (`MM_COLS * `MM_KCH)
    ) b_bram_i (
        .clk     (clk),
        .wr_en   (b_bram_wr_en),
        .wr_addr (b_wr_addr),
        .wr_data (b_wr_data),
        .rd_en   (rd_en),     // Same read strobe as A
        .rd_addr (b_rd_addr),
        .rd_data (b_rd_word)
    );

    tile_sequencer seq_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .load_open   (load_open),
        .rd_en       (rd_en),
        .a_rd_addr   (a_rd_addr),
        .b_rd_addr   (b_rd_addr),
        .chunk_valid (chunk_valid),
        .chunk_first (chunk_first),
        .chunk_last  (chunk_last),
        .done        (done)
    );

    dot_product_engine engine_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_word      (a_rd_word),
        .b_word      (b_rd_word),
        .chunk_valid (chunk_valid),
        .chunk_first (chunk_first),
        .chunk_last  (chunk_last),
        .out_data    (out_data),
        .out_valid   (out_valid)
    );

endmodule

// ==== verification/matmul_tb.sv ====
// Matmul testbench
`timescale 1ns/1ps
`include "matmul_settings.svh"

module matmul_tb import matmul_pkg::*; ();

    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 8;
    localparam int N_RESULTS    = `MM_ROWS * `MM_COLS;
    localparam int A_WORDS      = `MM_ROWS * `MM_KCH;
    localparam int B_WORDS      = `MM_COLS * `MM_KCH;
    // Start, all reads, drain, done, plus quiet check after it
    localparam int JOB_CYCLES   = 2 + N_RESULTS * `MM_KCH + `MM_PIPE_LAT + 1;
    localparam int QUIET_CYCLES = 2 * `MM_KCH;
    localparam int LOAD_CYCLES  = 2 * (A_WORDS + B_WORDS + 2);
    localparam int WATCHDOG_CYCLES =
        2 * (2 * (JOB_CYCLES + QUIET_CYCLES)) + LOAD_CYCLES + RESET_CYCLES + 4;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    start;
    logic    a_wr_en;
    a_addr_t a_wr_addr;
    word_t   a_wr_data;
    logic    b_wr_en;
    b_addr_t b_wr_addr;
    word_t   b_wr_data;
    result_t out_data;
    logic    out_valid;
    logic    done;

    // Operands and expected results in row-major order
    elem_t   a_mat [`MM_ROWS][`MM_INNER];
    elem_t   b_mat [`MM_COLS][`MM_INNER];
    result_t exp_q [$];

    integer seed;
    int     cycle_cnt = 0;
    int     last_pulse = 0;  // Cycle of the latest out_valid
    int     got_cnt = 0;     // Results seen in this job
    bit     have_pulse = 1'b0;
    bit     prev_done = 1'b0;
    bit     prev_start = 1'b0;
    bit     prev_rst_n = 1'b0;
    string  test_name = "reset";

    matmul_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .a_wr_en   (a_wr_en),
        .a_wr_addr (a_wr_addr),
        .a_wr_data (a_wr_data),
        .b_wr_en   (b_wr_en),
        .b_wr_addr (b_wr_addr),
        .b_wr_data (b_wr_data),
        .out_data  (out_data),
        .out_valid (out_valid),
        .done      (done)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_fail(input string test, input int expected, input int actual);
        string line;
        line = $sformatf("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
        stop_run(line);
    endtask

    // Output monitor on pre-edge values
    always @(posedge clk) begin
        cycle_cnt++;
        // Reset not yet applied on the first edge
        if ((!rst_n && cycle_cnt > 1) || (rst_n && !prev_rst_n)) begin
            assert (!out_valid && !done)
                else report_fail("reset", 0, {out_valid, done});
        end
        if (prev_start) begin
            have_pulse = 1'b0;  // New job has no interval yet
        end
        if (out_valid) begin
            assert (exp_q.size() > 0)
                else stop_run("out_valid pulsed with no result pending");
            assert (!done) else report_fail("streaming", 0, done);
            assert (out_data == exp_q[0])
                else report_fail(test_name, exp_q[0], out_data);
            exp_q.delete(0);
            if (have_pulse) begin
                assert (cycle_cnt - last_pulse == `MM_KCH)
                    else report_fail("streaming", `MM_KCH, cycle_cnt - last_pulse);
            end
            have_pulse = 1'b1;
            last_pulse = cycle_cnt;
            got_cnt++;
        end
        // done one cycle after the last pulse
        if (done && !prev_done) begin
            assert (have_pulse && (cycle_cnt - last_pulse == 1))
                else report_fail("done timing", 1, cycle_cnt - last_pulse);
        end
        if (!done && prev_done) begin
            assert (prev_start) else stop_run("done fell without a start");
        end
        prev_done  = done;
        prev_start = start;
        prev_rst_n = rst_n;
    end

    // Fill both RAMs with random data and queue the reference results
    task automatic load_matrices();
        int    acc;
        word_t word;
        for (int r = 0; r < `MM_ROWS; r++)
            for (int k = 0; k < `MM_INNER; k++)
                a_mat[r][k] = elem_t'($random(seed));
        for (int c = 0; c < `MM_COLS; c++)
            for (int k = 0; k < `MM_INNER; k++)
                b_mat[c][k] = elem_t'($random(seed));
        a_mat[0][0] = elem_t'(-128);  // Most negative operand pair
        b_mat[0][0] = elem_t'(-128);
        for (int r = 0; r < `MM_ROWS; r++) begin
            for (int c = 0; c < `MM_COLS; c++) begin
                acc = 0;
                for (int k = 0; k < `MM_INNER; k++) begin
                    acc += int'(a_mat[r][k]) * int'(b_mat[c][k]);
                end
                exp_q.push_back(result_t'(acc >>> `MM_FRAC)); // Low OUT_W bits
            end
        end
        // Word w holds row w / KCH, chunk w % KCH
        for (int w = 0; w < A_WORDS; w++) begin
            for (int i = 0; i < `MM_CHUNK; i++)
                word[i*`MM_ELEM_W +: `MM_ELEM_W] =
                    a_mat[w / `MM_KCH][(w % `MM_KCH) * `MM_CHUNK + i];
            a_wr_en   <= 1'b1;
            a_wr_addr <= a_addr_t'(w);
            a_wr_data <= word;
            @(posedge clk);
        end
        a_wr_en <= 1'b0;
        for (int w = 0; w < B_WORDS; w++) begin
            for (int i = 0; i < `MM_CHUNK; i++)
                word[i*`MM_ELEM_W +: `MM_ELEM_W] =
                    b_mat[w / `MM_KCH][(w % `MM_KCH) * `MM_CHUNK + i];
            b_wr_en   <= 1'b1;
            b_wr_addr <= b_addr_t'(w);
            b_wr_data <= word;
            @(posedge clk);
        end
        b_wr_en <= 1'b0;
    endtask

    // One job with random writes to both RAMs while it runs
    task automatic run_job(input string name);
        int waited;
        test_name = name;
        got_cnt   = 0;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        assert (!done) else report_fail({name, " done clear"}, 0, done);
        waited = 0;
        while (!done && waited < 2 * JOB_CYCLES) begin
            a_wr_en   <= 1'b1;  // Dropped while the load port is closed
            a_wr_addr <= a_addr_t'($random(seed));
            a_wr_data <= word_t'($random(seed));
            b_wr_en   <= 1'b1;
            b_wr_addr <= b_addr_t'($random(seed));
            b_wr_data <= word_t'($random(seed));
            @(posedge clk);
            waited++;
        end
        a_wr_en <= 1'b0;
        b_wr_en <= 1'b0;
        if (!done) begin
            stop_run({name, ": done did not rise before the job timeout"});
        end
        assert (got_cnt == N_RESULTS) else report_fail({name, " count"}, N_RESULTS, got_cnt);
        repeat (QUIET_CYCLES) @(posedge clk);  // Monitor flags stray pulses
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        stop_run("Watchdog timeout, the run did not finish in time");
    end

    initial begin
        seed      = 12512;
        rst_n     = 1'b0;
        start     = 1'b0;
        a_wr_en   = 1'b0;
        a_wr_addr = '0;
        a_wr_data = '0;
        b_wr_en   = 1'b0;
        b_wr_addr = '0;
        b_wr_data = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        load_matrices();
        run_job("results");
        // Reload while done is high, then restart
        load_matrices();
        run_job("restart");
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+source
source/matmul_pkg.sv
source/dual_port_bram.sv
source/tile_sequencer.sv
source/dot_product_engine.sv
source/matmul_top.sv
verification/matmul_tb.sv

// ==== Bender.yml ====
package:
  name: matmul

export_include_dirs:
  - source

sources:
  - files:
      - source/matmul_pkg.sv
      - source/dual_port_bram.sv
      - source/tile_sequencer.sv
      - source/dot_product_engine.sv
      - source/matmul_top.sv
  - target: test
    files:
      - verification/matmul_tb.sv
